// File: design/uart_dbg_pkg.sv
// Constants are fixed at elaboration; only the low WB_ADDR_W and LEN_W bits of a field are kept
package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Serial timing
  ////////////////////////////////////////////////////////////////////////////

  // Kept small so that simulation stays short
  localparam int unsigned CLKS_PER_BIT = 16;
  localparam int unsigned BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  ////////////////////////////////////////////////////////////////////////////
  // Protocol byte codes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [7:0] CMD_READ  = 8'h11;
  localparam logic [7:0] CMD_WRITE = 8'h12;
  localparam logic [7:0] CMD_EXEC  = 8'h13;
  localparam logic [7:0] BYTE_ACK  = 8'h06;
  localparam logic [7:0] BYTE_EOT  = 8'h04;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned WB_ADDR_W   = 32;
  localparam int unsigned LEN_W       = 16;
  // Address and length always travel as 8 bytes, LSB first
  localparam int unsigned FIELD_BYTES = 8;
  localparam int unsigned FIELD_CNT_W = $clog2(FIELD_BYTES);

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0]           byte_t;
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [LEN_W-1:0]     xfer_len_t;

  // One received byte, valid for a single cycle
  typedef struct packed {
    logic  valid;
    byte_t data;
  } rx_byte_t;

  // Wishbone classic request, byte wide
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    byte_t    dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    byte_t dat;
  } wb_rsp_t;

endpackage

// File: design/uart_dbg_rx.sv
// 8N1 receiver without parity or back-pressure; a frame with a low stop bit is dropped silently
`timescale 1ns/1ps

module uart_dbg_rx (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   rx_i,
  output uart_dbg_pkg::rx_byte_t byte_o
);

  import uart_dbg_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e              state_q;
  logic                   rx_meta_q;
  logic                   rx_sync_q;
  logic [BIT_CNT_W-1:0]   cnt_q;
  logic [2:0]             bit_q;
  logic                   valid_q;
  byte_t                  shift_q;
  logic                   bit_end;

  // Line idles high, so the synchronizer comes out of reset high
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  assign bit_end = (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      cnt_q   <= cnt_q + 1'b1;
      unique case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_sync_q) state_q <= RX_START;
        end
        RX_START: begin
          // Middle of start bit; a high line here was only a glitch
          if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            valid_q <= rx_sync_q;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) shift_q <= {rx_sync_q, shift_q[7:1]};
  end

  assign byte_o = '{valid: valid_q, data: shift_q};

  // Strobe closes the frame whose start bit was sampled low nine bit times earlier
  a_strobe_after_stop : assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_q |-> !$past(rx_sync_q, 9 * CLKS_PER_BIT + 1))
    else $error("rx strobe inside a frame");

endmodule

// File: design/uart_dbg_tx.sv
// 8N1 transmitter without parity; start_i is only legal while busy_o is low
`timescale 1ns/1ps

module uart_dbg_tx (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  uart_dbg_pkg::byte_t data_i,
  output logic                busy_o,
  output logic                tx_o
);

  import uart_dbg_pkg::*;

  // Stop, data and start bit; bit 0 is on the line
  logic [9:0]           shift_q;
  logic [BIT_CNT_W-1:0] cnt_q;
  logic [3:0]           bit_q;
  logic                 busy_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_q <= '1;
      cnt_q   <= '0;
      bit_q   <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (start_i) begin
        shift_q <= {1'b1, data_i, 1'b0};
        cnt_q   <= '0;
        bit_q   <= '0;
        busy_q  <= 1'b1;
      end
    end else if (cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1)) begin
      cnt_q   <= '0;
      // Ones fill in behind, so the line idles high afterwards
      shift_q <= {1'b1, shift_q[9:1]};
      if (bit_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tx_o   = shift_q[0];
  assign busy_o = busy_q;

  // Engine must hold off while a frame is going out
  a_no_start_when_busy : assert property (@(posedge clk) disable iff (!rst_n_i)
    busy_q |-> !start_i)
    else $error("tx start while busy");

endmodule

// File: design/uart_dbg_engine.sv
// One Wishbone access in flight at a time; each write access must end within one frame time
`timescale 1ns/1ps

module uart_dbg_engine (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  uart_dbg_pkg::rx_byte_t   rx_byte_i,
  output logic                     tx_start_o,
  output uart_dbg_pkg::byte_t      tx_byte_o,
  input  logic                     tx_busy_i,
  output uart_dbg_pkg::wb_req_t    wb_req_o,
  input  uart_dbg_pkg::wb_rsp_t    wb_rsp_i,
  output logic                     launch_o,
  output uart_dbg_pkg::wb_addr_t   entry_o
);

  import uart_dbg_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_LEN,
    S_ACK,
    S_DATA,
    S_EOT,
    S_EXEC
  } state_e;

  state_e                 state_q;
  byte_t                  cmd_q;
  logic [FIELD_CNT_W-1:0] fld_cnt_q;
  wb_addr_t               addr_q;
  xfer_len_t              len_q;
  wb_req_t                wb_q;
  byte_t                  tx_byte_q;
  logic                   tx_pend_q;
  logic                   tx_fire;
  logic                   last_fld;
  logic                   is_rw;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // A pending byte leaves as soon as the transmitter is free
  assign tx_fire  = tx_pend_q && !tx_busy_i;
  assign last_fld = (fld_cnt_q == FIELD_CNT_W'(FIELD_BYTES - 1));
  assign is_rw    = (cmd_q == CMD_READ) || (cmd_q == CMD_WRITE);

  ////////////////////////////////////////////////////////////////////////////
  // Protocol FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      cmd_q     <= '0;
      fld_cnt_q <= '0;
      addr_q    <= '0;
      len_q     <= '0;
      wb_q      <= '0;
      tx_byte_q <= '0;
      tx_pend_q <= 1'b0;
    end else begin
      if (tx_fire) tx_pend_q <= 1'b0;
      unique case (state_q)
        S_IDLE: begin
          fld_cnt_q <= '0;
          if (rx_byte_i.valid) begin
            cmd_q <= rx_byte_i.data;
            case (rx_byte_i.data)
              CMD_READ, CMD_WRITE, CMD_EXEC: state_q <= S_ADDR;
              BYTE_ACK: begin
                state_q   <= S_ACK;
                tx_byte_q <= BYTE_ACK;
                tx_pend_q <= 1'b1;
              end
              default: state_q <= S_IDLE;
            endcase
          end
        end
        S_ADDR: begin
          if (rx_byte_i.valid) begin
            // Upper bytes beyond the bus width are dropped
            if (fld_cnt_q < WB_ADDR_W / 8) addr_q[8*fld_cnt_q +: 8] <= rx_byte_i.data;
            fld_cnt_q <= fld_cnt_q + 1'b1;
            if (last_fld) state_q <= (cmd_q == CMD_EXEC) ? S_EXEC : S_LEN;
          end
        end
        S_LEN: begin
          if (rx_byte_i.valid) begin
            if (fld_cnt_q < LEN_W / 8) len_q[8*fld_cnt_q +: 8] <= rx_byte_i.data;
            fld_cnt_q <= fld_cnt_q + 1'b1;
            if (last_fld) begin
              state_q   <= S_ACK;
              tx_byte_q <= BYTE_ACK;
              tx_pend_q <= 1'b1;
            end
          end
        end
        S_EXEC: begin
          // launch_o is up for this single cycle
          state_q   <= S_ACK;
          tx_byte_q <= BYTE_ACK;
          tx_pend_q <= 1'b1;
        end
        S_ACK: begin
          if (tx_fire) state_q <= is_rw ? S_DATA : S_IDLE;
        end
        S_DATA: begin
          if (wb_q.cyc) begin
            if (wb_rsp_i.ack) begin
              wb_q.cyc <= 1'b0;
              wb_q.stb <= 1'b0;
              addr_q   <= addr_q + wb_addr_t'(1);
              len_q    <= len_q - xfer_len_t'(1);
              // Read data is taken in the ack cycle
              if (!wb_q.we) begin
                tx_byte_q <= wb_rsp_i.dat;
                tx_pend_q <= 1'b1;
              end
            end
          end else if (len_q == '0) begin
            // Last read byte must be handed off before EOT
            if (!tx_pend_q) begin
              state_q   <= S_EOT;
              tx_byte_q <= BYTE_EOT;
              tx_pend_q <= 1'b1;
            end
          end else if (cmd_q == CMD_READ) begin
            if (!tx_pend_q) begin
              wb_q.cyc <= 1'b1;
              wb_q.stb <= 1'b1;
              wb_q.we  <= 1'b0;
              wb_q.adr <= addr_q;
            end
          end else if (rx_byte_i.valid) begin
            wb_q.cyc <= 1'b1;
            wb_q.stb <= 1'b1;
            wb_q.we  <= 1'b1;
            wb_q.adr <= addr_q;
            wb_q.dat <= rx_byte_i.data;
          end
        end
        S_EOT: begin
          if (tx_fire) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign tx_start_o = tx_fire;
  assign tx_byte_o  = tx_byte_q;
  assign wb_req_o   = wb_q;
  assign launch_o   = (state_q == S_EXEC);
  assign entry_o    = addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Bus checks
  ////////////////////////////////////////////////////////////////////////////

  a_stb_in_cyc : assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_q.stb |-> wb_q.cyc)
    else $error("wb stb without cyc");

  // Request holds until the slave acks
  a_adr_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_q.stb && !wb_rsp_i.ack |=> wb_q.stb && $stable(wb_q.adr))
    else $error("wb request changed before ack");

endmodule

// File: design/uart_dbg_top.sv
// UART debug target; the bus side must ack every write within one serial frame time
`timescale 1ns/1ps

module uart_dbg_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o,
  output uart_dbg_pkg::wb_req_t  wb_req_o,
  input  uart_dbg_pkg::wb_rsp_t  wb_rsp_i,
  output logic                   launch_o,
  output uart_dbg_pkg::wb_addr_t entry_o
);

  import uart_dbg_pkg::*;

  rx_byte_t rx_byte;
  logic     tx_start;
  byte_t    tx_byte;
  logic     tx_busy;

  // Serial in
  uart_dbg_rx u_rx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .rx_i    ( uart_rx_i ),
    .byte_o  ( rx_byte   )
  );

  // Command decode and bus master
  uart_dbg_engine u_engine (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n_i  ),
    .rx_byte_i  ( rx_byte  ),
    .tx_start_o ( tx_start ),
    .tx_byte_o  ( tx_byte  ),
    .tx_busy_i  ( tx_busy  ),
    .wb_req_o   ( wb_req_o ),
    .wb_rsp_i   ( wb_rsp_i ),
    .launch_o   ( launch_o ),
    .entry_o    ( entry_o  )
  );

  // Serial out
  uart_dbg_tx u_tx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .start_i ( tx_start  ),
    .data_i  ( tx_byte   ),
    .busy_o  ( tx_busy   ),
    .tx_o    ( uart_tx_o )
  );

endmodule

// File: tb/uart_dbg_tb.sv
// Host-side testbench; the memory model decodes only the low 8 address bits, rows carry up to 4 bytes
`timescale 1ns/1ps

module uart_dbg_tb;

  import uart_dbg_pkg::*;

  localparam int NUM_ROWS   = 8;
  localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
  // Longest silence before a reply is a full command header
  localparam int RX_TIMEOUT = 30 * FRAME_CLKS;

  typedef struct {
    string       name;
    byte_t       cmd;
    logic [63:0] addr;
    int          len;
    logic [31:0] data;
    wb_addr_t    entry;
  } test_row_t;

  logic      clk;
  logic      rst_n;
  logic      uart_rx;
  logic      uart_tx;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp = '0;
  logic      launch;
  wb_addr_t  entry;

  byte_t     mem     [256];
  byte_t     exp_mem [256];
  wb_addr_t  acc_adr [$];
  logic      acc_we  [$];
  int        launch_total = 0;
  wb_addr_t  launch_entry;
  int        wait_left;
  integer    seed = 32'hfceaef7c;
  test_row_t rows [NUM_ROWS];

  initial clk = 1'b0;
  always #5 clk = ~clk;

  uart_dbg_top dut0 (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n   ),
    .uart_rx_i ( uart_rx ),
    .uart_tx_o ( uart_tx ),
    .wb_req_o  ( wb_req  ),
    .wb_rsp_i  ( wb_rsp  ),
    .launch_o  ( launch  ),
    .entry_o   ( entry   )
  );

  function automatic byte_t fill_value(input int idx);
    // Odd multiplier keeps every address distinct
    return byte_t'(idx * 29 + 107);
  endfunction

  function automatic logic [7:0] mem_index(input wb_addr_t adr);
    return adr[7:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone memory with random wait states
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      wb_rsp    <= '0;
      wait_left = -1;
      for (int i = 0; i < 256; i++) mem[i] <= fill_value(i);
    end else begin
      wb_rsp.ack <= 1'b0;
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (wait_left < 0) wait_left = $random(seed) & 3;
        if (wait_left == 0) begin
          wb_rsp.ack <= 1'b1;
          wb_rsp.dat <= mem[mem_index(wb_req.adr)];
          if (wb_req.we) mem[mem_index(wb_req.adr)] <= wb_req.dat;
          acc_adr.push_back(wb_req.adr);
          acc_we.push_back(wb_req.we);
          wait_left = -1;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  // Launch pulses and the entry seen with them
  always @(negedge clk) begin
    if (rst_n && launch) begin
      launch_total = launch_total + 1;
      launch_entry = entry;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input wb_addr_t exp, input wb_addr_t act);
    if (act !== exp) abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Serial host
  ////////////////////////////////////////////////////////////////////////////

  // Called right after a rising edge
  task automatic send_byte(input byte_t value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  task automatic send_field(input logic [63:0] value);
    for (int i = 0; i < FIELD_BYTES; i++) send_byte(value[8*i +: 8]);
  endtask

  task automatic send_header(input test_row_t row);
    send_byte(row.cmd);
    send_field(row.addr);
    if (row.cmd != CMD_EXEC) send_field(64'(row.len));
  endtask

  // Samples on the falling edge, near the middle of each bit
  task automatic recv_byte(output byte_t value);
    int waited;
    waited = 0;
    value  = '0;
    while (uart_tx !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > RX_TIMEOUT) abort_run("Timed out waiting for a start bit on uart_tx_o");
    end
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      value[i] = uart_tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    if (uart_tx !== 1'b1) abort_run("Stop bit on uart_tx_o was low");
  endtask

  task automatic check_bus_log(input test_row_t row, input int first, input logic we_exp);
    wb_addr_t base;
    base = row.addr[WB_ADDR_W-1:0];
    if (acc_adr.size() - first != row.len) begin
      abort_run($sformatf("%s made %0d bus accesses instead of %0d",
                          row.name, acc_adr.size() - first, row.len));
    end
    for (int i = 0; i < row.len; i++) begin
      check_addr({row.name, " adr"}, base + wb_addr_t'(i), acc_adr[first + i]);
      check_flag({row.name, " we"}, we_exp, acc_we[first + i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_ack(input test_row_t row);
    byte_t got;
    fork
      send_byte(BYTE_ACK);
      recv_byte(got);
    join
    check_byte({row.name, " reply"}, BYTE_ACK, got);
    // A second reply would show up within two frames
    for (int i = 0; i < 2 * FRAME_CLKS; i++) begin
      @(negedge clk);
      check_flag({row.name, " idle"}, 1'b1, uart_tx);
    end
  endtask

  task automatic run_write(input test_row_t row);
    byte_t    got;
    wb_addr_t base;
    int       first;
    base  = row.addr[WB_ADDR_W-1:0];
    first = acc_adr.size();
    for (int i = 0; i < row.len; i++) exp_mem[mem_index(base + wb_addr_t'(i))] = row.data[8*i +: 8];
    fork
      send_header(row);
      recv_byte(got);
    join
    check_byte({row.name, " ack"}, BYTE_ACK, got);
    @(posedge clk);
    fork
      for (int i = 0; i < row.len; i++) send_byte(row.data[8*i +: 8]);
      recv_byte(got);
    join
    check_byte({row.name, " eot"}, BYTE_EOT, got);
    check_bus_log(row, first, 1'b1);
    for (int i = 0; i < row.len; i++) begin
      check_byte({row.name, " mem"}, exp_mem[mem_index(base + wb_addr_t'(i))],
                 mem[mem_index(base + wb_addr_t'(i))]);
    end
  endtask

  task automatic run_read(input test_row_t row);
    byte_t    got;
    wb_addr_t base;
    int       first;
    base  = row.addr[WB_ADDR_W-1:0];
    first = acc_adr.size();
    fork
      send_header(row);
      begin
        recv_byte(got);
        check_byte({row.name, " ack"}, BYTE_ACK, got);
        for (int i = 0; i < row.len; i++) begin
          recv_byte(got);
          check_byte({row.name, " data"}, exp_mem[mem_index(base + wb_addr_t'(i))], got);
        end
        recv_byte(got);
        check_byte({row.name, " eot"}, BYTE_EOT, got);
      end
    join
    check_bus_log(row, first, 1'b0);
  endtask

  task automatic run_exec(input test_row_t row);
    byte_t got;
    int    first;
    int    launches;
    first    = acc_adr.size();
    launches = launch_total;
    fork
      send_header(row);
      recv_byte(got);
    join
    check_byte({row.name, " ack"}, BYTE_ACK, got);
    if (launch_total - launches != 1) abort_run({row.name, " did not pulse launch_o once"});
    check_addr({row.name, " entry"}, row.entry, launch_entry);
    if (acc_adr.size() != first) abort_run({row.name, " touched the bus"});
  endtask

  task automatic set_row(input int idx, input string name, input byte_t cmd,
                         input logic [63:0] addr, input int len, input logic [31:0] data,
                         input wb_addr_t exp_entry);
    rows[idx].name  = name;
    rows[idx].cmd   = cmd;
    rows[idx].addr  = addr;
    rows[idx].len   = len;
    rows[idx].data  = data;
    rows[idx].entry = exp_entry;
  endtask

  initial begin
    rst_n   = 1'b0;
    uart_rx = 1'b1;
    for (int i = 0; i < 256; i++) exp_mem[i] = fill_value(i);
    set_row(0, "ack_challenge", BYTE_ACK, 64'h0, 0, 32'h0, 32'h0);
    set_row(1, "write_four", CMD_WRITE, 64'h0000_0000_0000_0010, 4, 32'hc3a5_5a3c, 32'h0);
    set_row(2, "read_back", CMD_READ, 64'h0000_0000_0000_0010, 4, 32'h0, 32'h0);
    set_row(3, "read_fill", CMD_READ, 64'h0000_0000_2000_00f0, 4, 32'h0, 32'h0);
    set_row(4, "write_upper", CMD_WRITE, 64'h5a5a_0001_0000_0040, 3, 32'h007e_8199, 32'h0);
    set_row(5, "read_upper_low", CMD_READ, 64'h0000_0000_0000_0040, 3, 32'h0, 32'h0);
    set_row(6, "read_upper_high", CMD_READ, 64'hffff_ffff_0000_0041, 2, 32'h0, 32'h0);
    set_row(7, "exec_entry", CMD_EXEC, 64'h0123_4567_8000_0100, 0, 32'h0, 32'h8000_0100);

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("reset_tx_idle", 1'b1, uart_tx);
    check_flag("reset_cyc", 1'b0, wb_req.cyc);
    check_flag("reset_launch", 1'b0, launch);

    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      case (rows[r].cmd)
        BYTE_ACK:  run_ack(rows[r]);
        CMD_WRITE: run_write(rows[r]);
        CMD_READ:  run_read(rows[r]);
        default:   run_exec(rows[r]);
      endcase
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// File: uart_dbg.f
design/uart_dbg_pkg.sv
design/uart_dbg_rx.sv
design/uart_dbg_tx.sv
design/uart_dbg_engine.sv
design/uart_dbg_top.sv
tb/uart_dbg_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the UART debug testbench; a nonzero exit status means failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module uart_dbg_tb -f uart_dbg.f -o uart_dbg_sim &&
./obj_dir/uart_dbg_sim ||
{
  echo "uart_dbg simulation run did not complete cleanly"
  exit 1
}
